//--- sim.f
rv_isa_pkg.sv
rv_ctrl_pkg.sv
decoder.sv
reg_file.sv
operand_stage.sv
alu.sv
shifter.sv
writeback_select.sv
rv_exec_core.sv
tb_rv_exec_core_asserts.sv
tb_rv_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_rv_exec_core
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_rv_exec_core.sv
module tb_rv_exec_core
  import rv_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // RV32E sized so that x16 and up decode as illegal
  localparam int NUM_REGS   = 16;
  localparam int GAP_CYCLES = 3;
  localparam int WAIT_LIMIT = 20;
  localparam bit GAP        = 1'b1;
  localparam bit B2B        = 1'b0;

  // One table row, expected values written by hand
  typedef struct {
    string       name;
    logic [31:0] inst;
    bit          gap;
    logic        exp_en;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_ill;
  } row_t;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc_addr;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        illegal_seen;

  row_t rows [$];
  int   issue_cycle [64];
  bit   issued [64];
  int   cycle = 0;
  int   pass_count = 0;
  int   fail_count = 0;
  bit   row_ok;

  rv_exec_core #(.NUM_REGS(NUM_REGS)) DUT (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .pc_addr(pc_addr),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .illegal_seen(illegal_seen)
  );

  always #50 clk = ~clk;

  // Edge counter, read only at falling edges and at issue
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Instruction word builders
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_R_TYPE};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, OP_I_TYPE};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OP_LUI};
  endfunction

  task automatic add_write(input string name, input logic [31:0] word, input bit gap,
                           input logic [4:0] rd, input logic [31:0] data);
    row_t r;
    r = '{name, word, gap, 1'b1, rd, data, 1'b0};
    rows.push_back(r);
  endtask

  // Rows that must not write, illegal or not
  task automatic add_quiet(input string name, input logic [31:0] word, input bit gap,
                           input logic ill);
    row_t r;
    r = '{name, word, gap, 1'b0, 5'd0, 32'd0, ill};
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Reset state and source values x1=100, x2=-7, x3=0x12345678
    add_write("addi_x5_zero", itype(12'h000, F3_ADD_SUB, 5'd1, 5'd5), GAP, 5'd1, 32'h0);
    add_write("addi_pos", itype(12'd100, F3_ADD_SUB, 5'd1, 5'd0), GAP, 5'd1, 32'h64);
    add_write("addi_neg", itype(12'hFF9, F3_ADD_SUB, 5'd2, 5'd0), GAP, 5'd2, 32'hFFFFFFF9);
    add_write("lui", utype(20'h12345, 5'd3), GAP, 5'd3, 32'h12345000);
    add_write("addi_low", itype(12'h678, F3_ADD_SUB, 5'd3, 5'd3), GAP, 5'd3, 32'h12345678);
    // R-type ALU
    add_write("add", rtype(F7_BASE, F3_ADD_SUB, 5'd4, 5'd1, 5'd2), GAP, 5'd4, 32'h5D);
    add_write("sub", rtype(F7_ALT, F3_ADD_SUB, 5'd5, 5'd1, 5'd2), B2B, 5'd5, 32'h6B);
    add_write("slt", rtype(F7_BASE, F3_SLT, 5'd6, 5'd2, 5'd1), B2B, 5'd6, 32'h1);
    add_write("sltu", rtype(F7_BASE, F3_SLTU, 5'd7, 5'd2, 5'd1), B2B, 5'd7, 32'h0);
    add_write("xor", rtype(F7_BASE, F3_XOR, 5'd8, 5'd3, 5'd1), B2B, 5'd8, 32'h1234561C);
    add_write("or", rtype(F7_BASE, F3_OR, 5'd9, 5'd1, 5'd3), B2B, 5'd9, 32'h1234567C);
    add_write("and", rtype(F7_BASE, F3_AND, 5'd10, 5'd3, 5'd1), B2B, 5'd10, 32'h60);
    // OP-IMM, signed and unsigned compares disagree here
    add_write("slti", itype(12'd5, F3_SLT, 5'd11, 5'd2), B2B, 5'd11, 32'h1);
    add_write("sltiu", itype(12'd5, F3_SLTU, 5'd12, 5'd2), B2B, 5'd12, 32'h0);
    add_write("sltiu_max", itype(12'hFFF, F3_SLTU, 5'd13, 5'd1), B2B, 5'd13, 32'h1);
    add_write("slti_neg", itype(12'hFFF, F3_SLT, 5'd14, 5'd1), B2B, 5'd14, 32'h0);
    add_write("xori", itype(12'h0FF, F3_XOR, 5'd15, 5'd3), B2B, 5'd15, 32'h12345687);
    add_write("ori", itype(12'h700, F3_OR, 5'd4, 5'd1), B2B, 5'd4, 32'h764);
    add_write("andi", itype(12'hFF0, F3_AND, 5'd5, 5'd3), B2B, 5'd5, 32'h12345670);
    add_write("addi_m1", itype(12'hFFF, F3_ADD_SUB, 5'd6, 5'd2), B2B, 5'd6, 32'hFFFFFFF8);
    // Shifts of -7, register amount is 100 mod 32
    add_write("sll", rtype(F7_BASE, F3_SLL, 5'd7, 5'd2, 5'd1), B2B, 5'd7, 32'hFFFFFF90);
    add_write("srl", rtype(F7_BASE, F3_SRL_SRA, 5'd8, 5'd2, 5'd1), B2B, 5'd8, 32'h0FFFFFFF);
    add_write("sra", rtype(F7_ALT, F3_SRL_SRA, 5'd9, 5'd2, 5'd1), B2B, 5'd9, 32'hFFFFFFFF);
    add_write("slli", itype({F7_BASE, 5'd8}, F3_SLL, 5'd10, 5'd2), B2B, 5'd10, 32'hFFFFF900);
    add_write("srli", itype({F7_BASE, 5'd28}, F3_SRL_SRA, 5'd11, 5'd2), B2B, 5'd11, 32'hF);
    add_write("srai", itype({F7_ALT, 5'd1}, F3_SRL_SRA, 5'd12, 5'd2), B2B, 5'd12, 32'hFFFFFFFC);
    // Dependent chain, distance one from execute, two from writeback
    add_write("dep_base", itype(12'd5, F3_ADD_SUB, 5'd12, 5'd0), GAP, 5'd12, 32'h5);
    add_write("dep_ex", rtype(F7_BASE, F3_ADD_SUB, 5'd13, 5'd12, 5'd12), B2B, 5'd13, 32'hA);
    add_write("dep_wb", rtype(F7_ALT, F3_ADD_SUB, 5'd14, 5'd13, 5'd12), B2B, 5'd14, 32'h5);
    add_write("dep_slli", itype({F7_BASE, 5'd3}, F3_SLL, 5'd15, 5'd14), B2B, 5'd15, 32'h28);
    add_write("dep_mix", rtype(F7_BASE, F3_ADD_SUB, 5'd12, 5'd15, 5'd13), B2B, 5'd12, 32'h32);
    add_write("dep_lui", utype(20'hABCDE, 5'd13), B2B, 5'd13, 32'hABCDE000);
    add_write("dep_lui_ex", itype(12'h001, F3_ADD_SUB, 5'd13, 5'd13), B2B, 5'd13, 32'hABCDE001);
    add_write("dep_xor", rtype(F7_BASE, F3_XOR, 5'd14, 5'd13, 5'd12), B2B, 5'd14, 32'hABCDE033);
    // x0 as destination and as source
    add_quiet("write_x0", itype(12'd55, F3_ADD_SUB, 5'd0, 5'd1), GAP, 1'b0);
    add_write("read_x0_b2b", rtype(F7_BASE, F3_ADD_SUB, 5'd4, 5'd0, 5'd1), B2B, 5'd4, 32'h64);
    add_write("read_x0", itype(12'h000, F3_ADD_SUB, 5'd5, 5'd0), GAP, 5'd5, 32'h0);
    // Illegal words, each followed by a good one
    add_quiet("bad_opcode", 32'h0000007F, GAP, 1'b1);
    add_write("after_opcode", itype(12'd1, F3_ADD_SUB, 5'd6, 5'd1), B2B, 5'd6, 32'h65);
    add_quiet("bad_funct7", rtype(7'b0000001, F3_ADD_SUB, 5'd7, 5'd1, 5'd2), B2B, 1'b1);
    add_write("after_funct7", itype(12'd2, F3_ADD_SUB, 5'd7, 5'd1), B2B, 5'd7, 32'h66);
    add_quiet("bad_rd", itype(12'd1, F3_ADD_SUB, 5'd20, 5'd1), B2B, 1'b1);
    add_write("after_rd", itype(12'd3, F3_ADD_SUB, 5'd8, 5'd1), B2B, 5'd8, 32'h67);
    add_quiet("bad_rs1", rtype(F7_BASE, F3_ADD_SUB, 5'd9, 5'd17, 5'd1), B2B, 1'b1);
    add_write("after_rs1", rtype(F7_BASE, F3_ADD_SUB, 5'd9, 5'd8, 5'd1), B2B, 5'd9, 32'hCB);
  endtask

  task automatic compare_word(input string test, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error: %s wb_data expected 0x%08h, actual 0x%08h", test, exp, act);
      row_ok = 1'b0;
    end
  endtask

  task automatic compare_index(input string test, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) begin
      $display("Error: %s wb_rd expected %0d, actual %0d", test, exp, act);
      row_ok = 1'b0;
    end
  endtask

  task automatic compare_flag(input string test, input string what, input logic exp,
                              input logic act);
    if (act !== exp) begin
      $display("Error: %s %s expected %b, actual %b", test, what, exp, act);
      row_ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    if (row_ok) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: fail", name);
    end
  endtask

  task automatic score_row(input int j);
    row_ok = 1'b1;
    compare_flag(rows[j].name, "wb_en", rows[j].exp_en, wb_en);
    compare_flag(rows[j].name, "illegal_seen", rows[j].exp_ill, illegal_seen);
    // Index and data only mean something on a write
    if (rows[j].exp_en) begin
      compare_index(rows[j].name, rows[j].exp_rd, wb_rd);
      compare_word(rows[j].name, rows[j].exp_data, wb_data);
    end
    report_test(rows[j].name);
  endtask

  // Result window is the cycle after the second edge past issue
  function automatic bit result_due(input int j);
    return issued[j] && cycle == issue_cycle[j] + 2;
  endfunction

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc_addr    = '0;
    build_table();

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Quiet outputs before the first issue
    row_ok = 1'b1;
    repeat (3) begin
      @(negedge clk);
      compare_flag("idle_after_reset", "wb_en", 1'b0, wb_en);
      compare_flag("idle_after_reset", "illegal_seen", 1'b0, illegal_seen);
    end
    report_test("idle_after_reset");

    fork
      begin : issuer
        for (int i = 0; i < rows.size(); i++) begin
          if (rows[i].gap) begin
            // Idle slots let earlier writes reach the register file
            repeat (GAP_CYCLES) begin
              @(posedge clk);
              inst_valid <= 1'b0;
            end
          end
          @(posedge clk);
          inst_valid <= 1'b1;
          inst       <= rows[i].inst;
          pc_addr    <= pc_addr + 32'd4;
          // Counter takes this value at the same edge
          issue_cycle[i] = cycle + 1;
          issued[i]      = 1'b1;
        end
        @(posedge clk);
        inst_valid <= 1'b0;
      end
      begin : collector
        int wait_cnt;
        for (int j = 0; j < rows.size(); j++) begin
          wait_cnt = 0;
          while (!result_due(j) && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
          end
          if (result_due(j)) begin
            score_row(j);
          end else begin
            $display("Timeout: test %s gave no result within %0d cycles", rows[j].name,
                     WAIT_LIMIT);
            row_ok = 1'b0;
            report_test(rows[j].name);
          end
        end
      end
    join

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : tb_rv_exec_core

//--- tb_rv_exec_core_asserts.sv
module tb_rv_exec_core_asserts (
  input logic       clk,
  input logic       rst,
  input logic       inst_valid,
  input logic       wb_en,
  input logic [4:0] wb_rd,
  input logic       illegal_seen
);

  timeunit 1ns;
  timeprecision 1ps;

  // x0 is never a writeback target
  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wb_en |-> wb_rd != 5'd0)
    else $error("wb_en raised with wb_rd of zero");

  // A slot either writes or flags, never both
  write_or_illegal: assert property (@(posedge clk) disable iff (rst)
    !(wb_en && illegal_seen))
    else $error("wb_en and illegal_seen high together");

  // Fixed latency of two cycles from issue
  two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
    (wb_en || illegal_seen) |-> $past(inst_valid, 2))
    else $error("writeback pulse without an issue two cycles earlier");

  // Sync reset clears both pulses by the next edge
  reset_quiet: assert property (@(posedge clk)
    rst |=> !wb_en && !illegal_seen)
    else $error("outputs active while in reset");

endmodule : tb_rv_exec_core_asserts

bind rv_exec_core tb_rv_exec_core_asserts u_asserts (
  .clk(clk), .rst(rst), .inst_valid(inst_valid),
  .wb_en(wb_en), .wb_rd(wb_rd), .illegal_seen(illegal_seen)
);

//--- rv_exec_core.sv
module rv_exec_core
  import rv_ctrl_pkg::*;
#(
  // 32 for RV32I, 16 for RV32E
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        inst_valid,
  input  logic [31:0] inst,
  input  logic [31:0] pc_addr,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic        illegal_seen
);

  // Decode
  ex_unit_e    dec_unit;
  alu_op_e     dec_op;
  logic [31:0] dec_imm;
  logic        dec_imm_en;
  logic        dec_rs1_en;
  logic        dec_rs2_en;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic        dec_rd_en;
  logic [4:0]  dec_rd;
  logic        dec_illegal;
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;

  // Execute
  logic        ex_valid;
  alu_op_e     ex_op;
  ex_unit_e    ex_unit;
  logic        ex_rd_en;
  logic [4:0]  ex_rd;
  logic        ex_illegal;
  logic [31:0] ex_a;
  logic [31:0] ex_b;
  logic [31:0] alu_result;
  logic [31:0] shift_result;
  logic [31:0] fwd_result;

  decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
    .rst(rst), .inst_valid(inst_valid), .inst(inst), .pc_addr(pc_addr),
    .ex_unit(dec_unit), .op(dec_op), .imm(dec_imm), .imm_en(dec_imm_en),
    .rs1_en(dec_rs1_en), .rs2_en(dec_rs2_en), .rs1(dec_rs1), .rs2(dec_rs2),
    .rd_en(dec_rd_en), .rd(dec_rd), .illegal(dec_illegal)
  );

  // Written from the writeback register
  reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
    .clk(clk), .rst(rst), .we(wb_en), .waddr(wb_rd), .wdata(wb_data),
    .raddr_a(dec_rs1), .raddr_b(dec_rs2), .rdata_a(rdata_a), .rdata_b(rdata_b)
  );

  operand_stage u_operand_stage (
    .clk(clk), .rst(rst), .inst_valid(inst_valid),
    .op(dec_op), .unit(dec_unit), .imm(dec_imm), .imm_en(dec_imm_en),
    .rs1_en(dec_rs1_en), .rs2_en(dec_rs2_en), .rs1(dec_rs1), .rs2(dec_rs2),
    .rd_en(dec_rd_en), .rd(dec_rd), .illegal(dec_illegal),
    .rdata_a(rdata_a), .rdata_b(rdata_b), .fwd_result(fwd_result),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_unit(ex_unit), .ex_rd_en(ex_rd_en),
    .ex_rd(ex_rd), .ex_illegal(ex_illegal), .ex_a(ex_a), .ex_b(ex_b)
  );

  // Both units see every operation
  alu u_alu (.op(ex_op), .a(ex_a), .b(ex_b), .result(alu_result));

  shifter u_shifter (.op(ex_op), .a(ex_a), .shamt(ex_b[4:0]), .result(shift_result));

  writeback_select u_writeback_select (
    .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_unit(ex_unit),
    .ex_rd_en(ex_rd_en), .ex_rd(ex_rd), .ex_illegal(ex_illegal),
    .alu_result(alu_result), .shift_result(shift_result), .ex_b(ex_b),
    .fwd_result(fwd_result), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .illegal_seen(illegal_seen)
  );

endmodule : rv_exec_core

//--- writeback_select.sv
module writeback_select
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        ex_valid,
  input  ex_unit_e    ex_unit,
  input  logic        ex_rd_en,
  input  logic [4:0]  ex_rd,
  input  logic        ex_illegal,
  input  logic [31:0] alu_result,
  input  logic [31:0] shift_result,
  input  logic [31:0] ex_b,
  output logic [31:0] fwd_result,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic        illegal_seen
);

  // Execute-stage result, also the first bypass source
  always_comb begin
    case (ex_unit)
      EX_ALU_UNIT:       fwd_result = alu_result;
      EX_SHIFT_UNIT:     fwd_result = shift_result;
      // LUI immediate rides on operand b
      EX_FORWARDER_UNIT: fwd_result = ex_b;
      default:           fwd_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_en        <= 1'b0;
      wb_rd        <= '0;
      wb_data      <= '0;
      illegal_seen <= 1'b0;
    end else begin
      // One-cycle pulses
      wb_en        <= ex_valid && ex_rd_en;
      illegal_seen <= ex_valid && ex_illegal;
      // Hold last write when idle
      if (ex_valid && ex_rd_en) begin
        wb_rd   <= ex_rd;
        wb_data <= fwd_result;
      end
    end
  end

endmodule : writeback_select

//--- shifter.sv
module shifter
  import rv_ctrl_pkg::*;
(
  input  alu_op_e     op,
  input  logic [31:0] a,
  input  logic [4:0]  shamt,
  output logic [31:0] result
);

  logic        right;
  logic        fill;
  logic [31:0] stage [6];

  assign right = (op == ALU_SRL) || (op == ALU_SRA);
  // Sign fill only for arithmetic right
  assign fill  = (op == ALU_SRA) && a[31];

  // Left shift runs through the right shifter bit-reversed
  assign stage[0] = right ? a : {<<{a}};

  // Five stages of 1, 2, 4, 8 and 16 bits
  for (genvar i = 0; i < 5; i++) begin : g_stage
    localparam int STEP = 1 << i;
    assign stage[i+1] = shamt[i] ? {{STEP{fill}}, stage[i][31:STEP]} : stage[i];
  end

  always_comb begin
    case (op)
      ALU_SLL:          result = {<<{stage[5]}};
      ALU_SRL, ALU_SRA: result = stage[5];
      default:          result = '0;
    endcase
  end

endmodule : shifter

//--- alu.sv
module alu
  import rv_ctrl_pkg::*;
(
  input  alu_op_e     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result
);

  logic        lt_signed;
  logic        lt_unsigned;
  logic [31:0] sum;
  logic [31:0] diff;

  assign sum         = a + b;
  assign diff        = a - b;
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = sum;
      ALU_SUB:  result = diff;
      // Compares give 0 or 1
      ALU_SLT:  result = {31'b0, lt_signed};
      ALU_SLTU: result = {31'b0, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      // Shifts and NOP belong elsewhere
      default:  result = '0;
    endcase
  end

endmodule : alu

//--- operand_stage.sv
module operand_stage
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        inst_valid,
  // Decoder outputs
  input  alu_op_e     op,
  input  ex_unit_e    unit,
  input  logic [31:0] imm,
  input  logic        imm_en,
  input  logic        rs1_en,
  input  logic        rs2_en,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        rd_en,
  input  logic [4:0]  rd,
  input  logic        illegal,
  // Register file and bypass sources
  input  logic [31:0] rdata_a,
  input  logic [31:0] rdata_b,
  input  logic [31:0] fwd_result,
  input  logic        wb_en,
  input  logic [4:0]  wb_rd,
  input  logic [31:0] wb_data,
  output logic        ex_valid,
  output alu_op_e     ex_op,
  output ex_unit_e    ex_unit,
  output logic        ex_rd_en,
  output logic [4:0]  ex_rd,
  output logic        ex_illegal,
  output logic [31:0] ex_a,
  output logic [31:0] ex_b
);

  logic [31:0] opnd_a;
  logic [31:0] opnd_b;

  // Newest producer wins: execute, then writeback, then register file
  function automatic logic [31:0] bypass(input logic [4:0] idx, input logic [31:0] rf_data);
    if (idx == '0) begin
      return '0;
    end else if (ex_valid && ex_rd_en && ex_rd == idx) begin
      return fwd_result;
    end else if (wb_en && wb_rd == idx) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  assign opnd_a = rs1_en ? bypass(rs1, rdata_a) : '0;
  // Immediate replaces rs2 for OP-IMM and LUI
  assign opnd_b = imm_en ? imm : (rs2_en ? bypass(rs2, rdata_b) : '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid   <= 1'b0;
      ex_op      <= ALU_NOP;
      ex_unit    <= EX_ERR_UNIT;
      ex_rd_en   <= 1'b0;
      ex_rd      <= '0;
      ex_illegal <= 1'b0;
    end else begin
      // Decoder fields are already clear on idle cycles
      ex_valid   <= inst_valid;
      ex_op      <= op;
      ex_unit    <= unit;
      ex_rd_en   <= rd_en;
      ex_rd      <= rd;
      ex_illegal <= illegal;
    end
  end

  // Operands only move on issue
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      ex_a <= opnd_a;
      ex_b <= opnd_b;
    end
  end

endmodule : operand_stage

//--- reg_file.sv
module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic [4:0]  raddr_a,
  input  logic [4:0]  raddr_b,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b
);

  // Index bits actually decoded; the decoder rejects larger indices
  localparam int AW = $clog2(NUM_REGS);

  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr[AW-1:0]] <= wdata;
    end
  end

  // Combinational reads, x0 pinned to zero
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a[AW-1:0]];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b[AW-1:0]];

endmodule : reg_file

//--- decoder.sv
module decoder
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
#(
  parameter int NUM_REGS = 32
) (
  input  logic        rst,
  input  logic        inst_valid,
  input  logic [31:0] inst,
  // Carried for AUIPC and jumps, not decoded in this slice
  input  logic [31:0] pc_addr,
  output ex_unit_e    ex_unit,
  output alu_op_e     op,
  output logic [31:0] imm,
  output logic        imm_en,
  output logic        rs1_en,
  output logic        rs2_en,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic        rd_en,
  output logic [4:0]  rd,
  output logic        illegal
);

  logic       issue;
  logic       bad;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] shamt;

  assign issue  = inst_valid && !rst;
  assign opcode = opcode_e'(inst[POS_OPCODE_HI:POS_OPCODE_LO]);
  assign funct3 = inst[POS_FUNCT3_HI:POS_FUNCT3_LO];
  assign funct7 = inst[POS_FUNCT7_HI:POS_FUNCT7_LO];
  assign shamt  = inst[POS_SHAMT_HI:POS_SHAMT_LO];

  always_comb begin
    // Clean outputs first
    ex_unit = EX_ERR_UNIT;
    op      = ALU_NOP;
    imm     = '0;
    imm_en  = 1'b0;
    rs1_en  = 1'b0;
    rs2_en  = 1'b0;
    rs1     = '0;
    rs2     = '0;
    rd_en   = 1'b0;
    rd      = '0;
    bad     = 1'b0;

    case (opcode)
      OP_R_TYPE: begin
        ex_unit = EX_ALU_UNIT;
        rs1_en  = 1'b1;
        rs2_en  = 1'b1;
        rs1     = inst[POS_RS1_HI:POS_RS1_LO];
        rs2     = inst[POS_RS2_HI:POS_RS2_LO];
        rd_en   = 1'b1;
        rd      = inst[POS_RD_HI:POS_RD_LO];
        case ({funct7, funct3})
          FUNCT73_ADD:  op = ALU_ADD;
          FUNCT73_SUB:  op = ALU_SUB;
          FUNCT73_SLT:  op = ALU_SLT;
          FUNCT73_SLTU: op = ALU_SLTU;
          FUNCT73_XOR:  op = ALU_XOR;
          FUNCT73_OR:   op = ALU_OR;
          FUNCT73_AND:  op = ALU_AND;
          // Register shifts use the low five bits of rs2
          FUNCT73_SLL: begin
            op      = ALU_SLL;
            ex_unit = EX_SHIFT_UNIT;
          end
          FUNCT73_SRL: begin
            op      = ALU_SRL;
            ex_unit = EX_SHIFT_UNIT;
          end
          FUNCT73_SRA: begin
            op      = ALU_SRA;
            ex_unit = EX_SHIFT_UNIT;
          end
          default: bad = 1'b1;
        endcase
      end

      OP_I_TYPE: begin
        ex_unit = EX_ALU_UNIT;
        // Sign-extended 12-bit immediate
        imm     = {{20{inst[POS_IMM_HI]}}, inst[POS_IMM_HI:POS_IMM_LO]};
        imm_en  = 1'b1;
        rs1_en  = 1'b1;
        rs1     = inst[POS_RS1_HI:POS_RS1_LO];
        rd_en   = 1'b1;
        rd      = inst[POS_RD_HI:POS_RD_LO];
        case (funct3)
          F3_ADD_SUB: op = ALU_ADD;
          F3_SLT:     op = ALU_SLT;
          F3_SLTU:    op = ALU_SLTU;
          F3_XOR:     op = ALU_XOR;
          F3_OR:      op = ALU_OR;
          F3_AND:     op = ALU_AND;
          F3_SLL: begin
            ex_unit = EX_SHIFT_UNIT;
            op      = ALU_SLL;
            imm     = {27'b0, shamt};
            bad     = (funct7 != F7_BASE);
          end
          F3_SRL_SRA: begin
            ex_unit = EX_SHIFT_UNIT;
            // Bit 30 picks arithmetic
            op      = inst[POS_ALT] ? ALU_SRA : ALU_SRL;
            imm     = {27'b0, shamt};
            bad     = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
          default: bad = 1'b1;
        endcase
      end

      OP_LUI: begin
        ex_unit = EX_FORWARDER_UNIT;
        // Upper 20 bits, low 12 zero
        imm     = {inst[POS_IMM_UI_HI:POS_IMM_UI_LO], 12'b0};
        imm_en  = 1'b1;
        rd_en   = 1'b1;
        rd      = inst[POS_RD_HI:POS_RD_LO];
      end

      default: bad = 1'b1;
    endcase

    // Indices beyond the register file, e.g. x16 and up on RV32E
    if ((rs1_en && rs1 >= NUM_REGS) || (rs2_en && rs2 >= NUM_REGS) ||
        (rd_en && rd >= NUM_REGS)) begin
      bad = 1'b1;
    end

    // x0 is never written
    if (rd == '0) begin
      rd_en = 1'b0;
    end

    illegal = issue && bad;

    // Nothing leaves the decoder for an idle slot or a bad word
    if (!issue || bad) begin
      ex_unit = EX_ERR_UNIT;
      op      = ALU_NOP;
      imm     = '0;
      imm_en  = 1'b0;
      rs1_en  = 1'b0;
      rs2_en  = 1'b0;
      rs1     = '0;
      rs2     = '0;
      rd_en   = 1'b0;
      rd      = '0;
    end
  end

endmodule : decoder

//--- rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // Operation carried from decode to the execute units
  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Unit whose result goes to writeback
  typedef enum logic [1:0] {
    EX_ERR_UNIT,
    EX_ALU_UNIT,
    EX_SHIFT_UNIT,
    EX_FORWARDER_UNIT
  } ex_unit_e;

endpackage : rv_ctrl_pkg

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // Major opcodes kept by this slice
  typedef enum logic [6:0] {
    OP_R_TYPE = 7'b0110011,
    OP_I_TYPE = 7'b0010011,
    OP_LUI    = 7'b0110111
  } opcode_e;

  // Funct3, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Funct7, base and alternate (SUB, SRA)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Merged {funct7, funct3} for R-type
  localparam logic [9:0] FUNCT73_ADD  = {F7_BASE, F3_ADD_SUB};
  localparam logic [9:0] FUNCT73_SUB  = {F7_ALT, F3_ADD_SUB};
  localparam logic [9:0] FUNCT73_SLL  = {F7_BASE, F3_SLL};
  localparam logic [9:0] FUNCT73_SLT  = {F7_BASE, F3_SLT};
  localparam logic [9:0] FUNCT73_SLTU = {F7_BASE, F3_SLTU};
  localparam logic [9:0] FUNCT73_XOR  = {F7_BASE, F3_XOR};
  localparam logic [9:0] FUNCT73_SRL  = {F7_BASE, F3_SRL_SRA};
  localparam logic [9:0] FUNCT73_SRA  = {F7_ALT, F3_SRL_SRA};
  localparam logic [9:0] FUNCT73_OR   = {F7_BASE, F3_OR};
  localparam logic [9:0] FUNCT73_AND  = {F7_BASE, F3_AND};

  // Instruction field positions
  localparam int POS_OPCODE_HI = 6;
  localparam int POS_OPCODE_LO = 0;
  localparam int POS_RD_HI     = 11;
  localparam int POS_RD_LO     = 7;
  localparam int POS_FUNCT3_HI = 14;
  localparam int POS_FUNCT3_LO = 12;
  localparam int POS_RS1_HI    = 19;
  localparam int POS_RS1_LO    = 15;
  localparam int POS_RS2_HI    = 24;
  localparam int POS_RS2_LO    = 20;
  localparam int POS_FUNCT7_HI = 31;
  localparam int POS_FUNCT7_LO = 25;
  localparam int POS_IMM_HI    = 31;
  localparam int POS_IMM_LO    = 20;
  localparam int POS_SHAMT_HI  = 24;
  localparam int POS_SHAMT_LO  = 20;
  localparam int POS_IMM_UI_HI = 31;
  localparam int POS_IMM_UI_LO = 12;
  // Alternate bit inside funct7
  localparam int POS_ALT       = 30;

endpackage : rv_isa_pkg
